// ==== files.f ====
src/cpuPkg.sv
src/regFileIf.sv
src/registerFile.sv
src/aluUnit.sv
src/dataRam.sv
src/instructionDecoder.sv
src/cpuCore.sv
tb/cpuCore_assertions.sv
tb/cpuCoreTb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS = --timing --assert
TOP = cpuCoreTb
FILELIST = files.f
BUILD_DIR = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(BUILD_DIR)

// ==== tb/cpuCoreTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpuCoreTb import cpuPkg::*; ();

	// Well above 175 instructions of at most four cycles each
	localparam int timeoutCycles = 2000;

	logic clock;
	logic rstN;
	logic instrValid;
	opcodeT opcode;
	wordT arg1;
	wordT arg2;
	logic busy;
	logic done;
	wordT result;
	logic jumpTaken;

	// Reference model state
	wordT modelRegs [16];
	wordT modelRam [ramAddrT];
	logic modelEqual;
	logic modelGreater;
	logic modelZero;

	logic [15:0] lfsrState;
	wordT lastResult;
	logic lastTaken;
	int errorCount;
	int checkCount;
	int cycleCount = 0;

	cpuCore i_cpuCore (
		.clock, .rstN, .instrValid, .opcode, .arg1, .arg2,
		.busy, .done, .result, .jumpTaken
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	always @(posedge clock) begin
		cycleCount++;
		if (cycleCount >= timeoutCycles) begin
			$display("Timeout: the tests did not finish within %0d clock cycles", cycleCount);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// Galois taps for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	function automatic wordT randomBits(input int n);
		wordT v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState);
			v = {v[dataWidth-2:0], lfsrState[0]};
		end
		return v;
	endfunction

	task automatic compareWord(input string name, input wordT expected, input wordT actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("Error in %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic compareBit(input string name, input logic expected, input logic actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("Error in %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	function automatic logic setsZero(input opcodeT op);
		return op inside {opAddReg, opAddConst, opSubReg, opSubConst, opXor, opOr, opAnd,
			opNot, opShl, opShr};
	endfunction

	// Expected outcome of one instruction and the matching model update
	task automatic predict(input opcodeT op, input wordT a1, input wordT a2,
			output wordT expResult, output logic expJump, output int expLatency);
		wordT a;
		wordT b;
		logic cond;
		a = modelRegs[a1[regAddrWidth-1:0]];
		b = modelRegs[a2[regAddrWidth-1:0]];
		expResult = '0;
		expJump = 1'b0;
		expLatency = 1;
		cond = 1'b1;
		case (op)
			opAddReg: expResult = a + b;
			opAddConst: expResult = a + a2;
			opSubReg: expResult = a - b;
			opSubConst: expResult = a - a2;
			opXor: expResult = a ^ b;
			opOr: expResult = a | b;
			opAnd: expResult = a & b;
			opNot: expResult = ~a;
			opShl: expResult = a << 1;
			opShr: expResult = a >> 1;
			opMovReg, opStoreReg: expResult = b;
			opMovConst, opStoreConst: expResult = a2;
			opLoad: begin
				expResult = modelRam[ramAddrT'(b)];
				expLatency = 2;
			end
			opCmp: expResult = a - b;
			default: begin
				case (op)
					opJzReg, opJzConst: cond = modelZero;
					opJnzReg, opJnzConst: cond = !modelZero;
					opJgReg, opJgConst: cond = modelGreater && !modelEqual;
					opJsReg, opJsConst: cond = !modelGreater && !modelEqual;
					opJeqReg, opJeqConst: cond = modelEqual;
					opJnqReg, opJnqConst: cond = !modelEqual;
					opJgqReg, opJgqConst: cond = modelGreater || modelEqual;
					opJsqReg, opJsqConst: cond = modelEqual || !modelGreater;
					// Plain JMP
					default: cond = 1'b1;
				endcase
				expJump = cond;
				expResult = (op inside {opJmpConst, opJzConst, opJnzConst, opJgConst, opJsConst,
					opJeqConst, opJnqConst, opJgqConst, opJsqConst}) ? a1 : a;
			end
		endcase
		if (setsZero(op)) begin
			modelZero = expResult == '0;
		end
		if (setsZero(op) || op inside {opMovReg, opMovConst, opLoad}) begin
			modelRegs[a1[regAddrWidth-1:0]] = expResult;
		end
		if (op inside {opStoreReg, opStoreConst}) begin
			modelRam[ramAddrT'(a)] = expResult;
		end
		if (op == opCmp) begin
			modelEqual = a == b;
			modelGreater = a > b;
			modelZero = a == b;
		end
	endtask

	// Issue once the core is idle and wait for done
	task automatic issue(input opcodeT op, input wordT a1, input wordT a2,
			output wordT res, output logic taken, output int latency);
		while (busy) begin
			@(posedge clock);
			#0.5;
		end
		instrValid = 1'b1;
		opcode = op;
		arg1 = a1;
		arg2 = a2;
		@(posedge clock);
		#0.5;
		instrValid = 1'b0;
		latency = 0;
		while (!done) begin
			@(posedge clock);
			#0.5;
			latency++;
		end
		res = result;
		taken = jumpTaken;
	endtask

	task automatic runAndCheck(input string name, input opcodeT op, input wordT a1,
			input wordT a2);
		wordT expResult;
		logic expJump;
		int expLatency;
		int latency;
		predict(op, a1, a2, expResult, expJump, expLatency);
		issue(op, a1, a2, lastResult, lastTaken, latency);
		compareWord(name, expResult, lastResult);
		compareBit(name, expJump, lastTaken);
		checkCount++;
		if (latency != expLatency) begin
			errorCount++;
			$display("Error in %s: done came %0d cycles after acceptance, expected %0d",
				name, latency, expLatency);
		end
	endtask

	task automatic resetAndConstMoves();
		compareBit("reset busy", 1'b0, busy);
		compareBit("reset done", 1'b0, done);
		compareBit("reset jumpTaken", 1'b0, jumpTaken);
		compareWord("reset result", '0, result);
		for (int r = 0; r < 16; r++) begin
			runAndCheck("mov const", opMovConst, wordT'(r), randomBits(dataWidth));
		end
	endtask

	task automatic aluOperations();
		opcodeT ops [8];
		ops = '{opAddReg, opSubReg, opXor, opOr, opAnd, opNot, opShl, opShr};
		for (int round = 0; round < 3; round++) begin
			foreach (ops[i]) begin
				runAndCheck("alu reg", ops[i], randomBits(4), randomBits(4));
			end
			runAndCheck("add const", opAddConst, randomBits(4), randomBits(dataWidth));
			runAndCheck("sub const", opSubConst, randomBits(4), randomBits(dataWidth));
			for (int k = 0; k < 4; k++) begin
				runAndCheck("mov reg copy", opMovReg, randomBits(4), randomBits(4));
			end
		end
	endtask

	task automatic storeAndLoad();
		wordT addrA;
		wordT addrB;
		for (int round = 0; round < 4; round++) begin
			addrA = randomBits(dataWidth);
			// Differs from addrA inside the RAM address bits
			addrB = addrA ^ 16'h0100;
			runAndCheck("store setup", opMovConst, 16'd1, addrA);
			runAndCheck("store setup", opMovConst, 16'd2, randomBits(dataWidth));
			runAndCheck("store setup", opMovConst, 16'd3, addrB);
			runAndCheck("store reg", opStoreReg, 16'd1, 16'd2);
			runAndCheck("store const", opStoreConst, 16'd3, randomBits(dataWidth));
			runAndCheck("load setup", opMovReg, 16'd4, 16'd1);
			runAndCheck("load setup", opMovReg, 16'd6, 16'd3);
			runAndCheck("load of store reg", opLoad, 16'd5, 16'd4);
			runAndCheck("load of store const", opLoad, 16'd7, 16'd6);
		end
	endtask

	task automatic compareAndJumps();
		opcodeT jumps [18];
		wordT base;
		wordT pairA [3];
		wordT pairB [3];
		// Register form at even index, constant form at odd
		jumps = '{opJmpReg, opJmpConst, opJzReg, opJzConst, opJnzReg, opJnzConst,
			opJgReg, opJgConst, opJsReg, opJsConst, opJeqReg, opJeqConst,
			opJnqReg, opJnqConst, opJgqReg, opJgqConst, opJsqReg, opJsqConst};
		base = randomBits(dataWidth) | 16'h8000;
		pairA = '{base, base, base >> 1};
		pairB = '{base, base >> 1, base};
		for (int c = 0; c < 3; c++) begin
			runAndCheck("cmp setup", opMovConst, 16'd8, pairA[c]);
			runAndCheck("cmp setup", opMovConst, 16'd9, pairB[c]);
			runAndCheck("target setup", opMovConst, 16'd10, randomBits(dataWidth));
			runAndCheck("cmp", opCmp, 16'd8, 16'd9);
			foreach (jumps[j]) begin
				runAndCheck("jump", jumps[j], (j % 2 == 0) ? 16'd10 : randomBits(dataWidth),
					16'd0);
				if (j < 2) begin
					compareBit("jmp always taken", 1'b1, lastTaken);
				end
			end
		end
	endtask

	task automatic zeroFlag();
		wordT v;
		v = randomBits(dataWidth) | 16'h0010;
		runAndCheck("zero setup", opMovConst, 16'd11, v);
		runAndCheck("sub self", opSubReg, 16'd11, 16'd11);
		runAndCheck("jz after zero", opJzConst, randomBits(dataWidth), 16'd0);
		compareBit("jz after zero", 1'b1, lastTaken);
		runAndCheck("jnz after zero", opJnzConst, randomBits(dataWidth), 16'd0);
		compareBit("jnz after zero", 1'b0, lastTaken);
		runAndCheck("zero setup", opMovConst, 16'd12, v);
		runAndCheck("zero setup", opMovConst, 16'd13, v ^ 16'h0001);
		runAndCheck("xor nonzero", opXor, 16'd12, 16'd13);
		runAndCheck("jz after nonzero", opJzReg, 16'd12, 16'd0);
		compareBit("jz after nonzero", 1'b0, lastTaken);
		runAndCheck("jnz after nonzero", opJnzReg, 16'd12, 16'd0);
		compareBit("jnz after nonzero", 1'b1, lastTaken);
	endtask

	task automatic ignoreWhileBusy();
		wordT keep;
		wordT first;
		wordT expResult;
		logic expJump;
		int expLatency;
		keep = randomBits(dataWidth);
		first = randomBits(dataWidth);
		runAndCheck("busy setup", opMovConst, 16'd14, keep);
		while (busy) begin
			@(posedge clock);
			#0.5;
		end
		predict(opMovConst, 16'd15, first, expResult, expJump, expLatency);
		instrValid = 1'b1;
		opcode = opMovConst;
		arg1 = 16'd15;
		arg2 = first;
		@(posedge clock);
		#0.5;
		// Intruder held through both busy edges
		arg1 = 16'd14;
		arg2 = ~keep;
		repeat (expLatency) begin
			@(posedge clock);
			#0.5;
		end
		compareBit("busy window done", 1'b1, done);
		compareWord("busy window result", expResult, result);
		compareBit("busy window jump", expJump, jumpTaken);
		@(posedge clock);
		#0.5;
		instrValid = 1'b0;
		@(posedge clock);
		#0.5;
		compareBit("no second done", 1'b0, done);
		compareBit("no second busy", 1'b0, busy);
		runAndCheck("busy copy", opMovReg, 16'd13, 16'd14);
		compareWord("busy copy", keep, lastResult);
	endtask

	initial begin
		rstN = 1'b0;
		instrValid = 1'b0;
		opcode = opMovConst;
		arg1 = '0;
		arg2 = '0;
		lfsrState = 16'd51944;
		errorCount = 0;
		checkCount = 0;
		modelEqual = 1'b0;
		modelGreater = 1'b0;
		modelZero = 1'b0;
		foreach (modelRegs[i]) begin
			modelRegs[i] = '0;
		end
		repeat (3) @(posedge clock);
		#0.5;
		rstN = 1'b1;
		resetAndConstMoves();
		aluOperations();
		storeAndLoad();
		compareAndJumps();
		zeroFlag();
		ignoreWhileBusy();
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/cpuCore_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpuCore_assertions (
	input wire logic clock,
	input wire logic rstN,
	input wire logic instrValid,
	input wire logic busy,
	input wire logic done,
	input wire logic jumpTaken
);

	// Completion is a single-cycle strobe
	doneSingleCycle: assert property (@(posedge clock) disable iff (!rstN) done |=> !done)
		else $error("done stayed high for more than one cycle");

	jumpOnlyWithDone: assert property (@(posedge clock) disable iff (!rstN) jumpTaken |-> done)
		else $error("jumpTaken high without done");

	doneOnlyWhileBusy: assert property (@(posedge clock) disable iff (!rstN) done |-> busy)
		else $error("done high while busy is low");

	// An accepted instruction raises busy at the next edge
	busyAfterAccept: assert property (@(posedge clock) disable iff (!rstN)
		(instrValid && !busy) |=> busy)
		else $error("busy did not rise after an accepted instruction");

endmodule

bind cpuCore cpuCore_assertions i_cpuCoreAssertions (
	.clock, .rstN, .instrValid, .busy, .done, .jumpTaken
);

`default_nettype wire

// ==== src/cpuCore.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpuCore import cpuPkg::*; (
	input wire logic clock,
	input wire logic rstN,
	input wire logic instrValid,
	input wire opcodeT opcode,
	input wire wordT arg1,
	input wire wordT arg2,
	output logic busy,
	output logic done,
	output wordT result,
	output logic jumpTaken
);

	regFileIf rfBus ();

	aluOpT aluOp;
	wordT operandA;
	wordT operandB;
	logic flagsUpdate;
	logic cmpUpdate;
	wordT aluResult;
	flagsT flags;
	ramAddrT ramAddr;
	logic ramWriteEn;
	wordT ramWriteData;
	wordT ramReadData;

	instructionDecoder i_instructionDecoder (
		.clock, .rstN, .instrValid, .opcode, .arg1, .arg2,
		.rf(rfBus.decoder),
		.aluOp, .operandA, .operandB, .flagsUpdate, .cmpUpdate, .aluResult, .flags,
		.ramAddr, .ramWriteEn, .ramWriteData, .ramReadData,
		.busy, .done, .result, .jumpTaken
	);

	registerFile i_registerFile (.clock, .rstN, .rf(rfBus.regFile));

	aluUnit i_aluUnit (
		.clock, .rstN, .aluOp, .operandA, .operandB, .flagsUpdate, .cmpUpdate,
		.aluResult, .flags
	);

	dataRam i_dataRam (.clock, .ramAddr, .ramWriteEn, .ramWriteData, .ramReadData);

endmodule

`default_nettype wire

// ==== src/instructionDecoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module instructionDecoder import cpuPkg::*; (
	input wire logic clock,
	input wire logic rstN,
	input wire logic instrValid,
	input wire opcodeT opcode,
	input wire wordT arg1,
	input wire wordT arg2,
	regFileIf.decoder rf,
	output aluOpT aluOp,
	output wordT operandA,
	output wordT operandB,
	output logic flagsUpdate,
	output logic cmpUpdate,
	input wire wordT aluResult,
	input wire flagsT flags,
	output ramAddrT ramAddr,
	output logic ramWriteEn,
	output wordT ramWriteData,
	input wire wordT ramReadData,
	output logic busy,
	output logic done,
	output wordT result,
	output logic jumpTaken
);

	typedef enum logic [1:0] {idle, execute, loadWait} stateT;

	stateT state;
	opcodeT opcodeQ;
	wordT arg1Q;
	wordT arg2Q;
	logic accept;
	logic constB;
	logic aluFlags;
	logic regWrite;
	logic ramStore;
	logic isLoad;
	logic cmpOp;
	logic isJump;
	logic jumpConst;
	logic condMet;
	wordT target;

	// Busy only drops in idle, so this alone is enough
	assign accept = instrValid && !busy;

	always_comb begin
		case (opcodeQ)
			opAddReg, opAddConst: aluOp = aluAdd;
			opSubReg, opSubConst, opCmp: aluOp = aluSub;
			opXor: aluOp = aluXor;
			opOr: aluOp = aluOr;
			opAnd: aluOp = aluAnd;
			opNot: aluOp = aluNot;
			opShl: aluOp = aluShl;
			opShr: aluOp = aluShr;
			default: aluOp = aluPass;
		endcase
	end

	assign constB = opcodeQ inside {opAddConst, opSubConst, opMovConst, opStoreConst};
	assign aluFlags = opcodeQ inside {opAddReg, opAddConst, opSubReg, opSubConst, opXor,
		opOr, opAnd, opNot, opShl, opShr};
	assign regWrite = aluFlags || opcodeQ inside {opMovReg, opMovConst};
	assign ramStore = opcodeQ inside {opStoreReg, opStoreConst};
	assign isLoad = opcodeQ == opLoad;
	assign cmpOp = opcodeQ == opCmp;
	assign jumpConst = opcodeQ inside {opJmpConst, opJzConst, opJnzConst, opJgConst,
		opJsConst, opJeqConst, opJnqConst, opJgqConst, opJsqConst};

	// Jump conditions against the flag word
	always_comb begin
		isJump = 1'b1;
		condMet = 1'b0;
		case (opcodeQ)
			opJmpReg, opJmpConst: condMet = 1'b1;
			opJzReg, opJzConst: condMet = flags.zero;
			opJnzReg, opJnzConst: condMet = !flags.zero;
			opJgReg, opJgConst: condMet = flags.greater && !flags.equal;
			opJsReg, opJsConst: condMet = !flags.greater && !flags.equal;
			opJeqReg, opJeqConst: condMet = flags.equal;
			opJnqReg, opJnqConst: condMet = !flags.equal;
			opJgqReg, opJgqConst: condMet = flags.greater || flags.equal;
			opJsqReg, opJsqConst: condMet = flags.equal || !flags.greater;
			default: isJump = 1'b0;
		endcase
	end

	assign rf.readAddrA = arg1Q[regAddrWidth-1:0];
	assign rf.readAddrB = arg2Q[regAddrWidth-1:0];
	assign operandA = rf.readDataA;
	assign operandB = constB ? arg2Q : rf.readDataB;
	assign target = jumpConst ? arg1Q : rf.readDataA;

	assign flagsUpdate = (state == execute) && aluFlags;
	assign cmpUpdate = (state == execute) && cmpOp;

	// Loads address through arg2, stores through arg1
	assign ramAddr = isLoad ? rf.readDataB[ramAddrWidth-1:0] : rf.readDataA[ramAddrWidth-1:0];
	assign ramWriteEn = (state == execute) && ramStore;
	assign ramWriteData = operandB;

	assign rf.writeEn = ((state == execute) && regWrite) || (state == loadWait);
	assign rf.writeAddr = arg1Q[regAddrWidth-1:0];
	assign rf.writeData = (state == loadWait) ? ramReadData : aluResult;

	always_ff @(posedge clock) begin
		if (!rstN) begin
			state <= idle;
			busy <= 1'b0;
			done <= 1'b0;
			jumpTaken <= 1'b0;
			result <= '0;
		end else begin
			done <= 1'b0;
			jumpTaken <= 1'b0;
			case (state)
				idle: begin
					// Also ends the busy stretch of the done cycle
					busy <= accept;
					if (accept) begin
						state <= execute;
					end
				end
				execute: begin
					if (isLoad) begin
						state <= loadWait;
					end else begin
						state <= idle;
						done <= 1'b1;
						jumpTaken <= isJump && condMet;
						result <= isJump ? target : aluResult;
					end
				end
				loadWait: begin
					state <= idle;
					done <= 1'b1;
					result <= ramReadData;
				end
				default: state <= idle;
			endcase
		end
	end

	// Instruction payload
	always_ff @(posedge clock) begin
		if (accept) begin
			opcodeQ <= opcode;
			arg1Q <= arg1;
			arg2Q <= arg2;
		end
	end

endmodule

`default_nettype wire

// ==== src/dataRam.sv ====
`timescale 1ns/100ps
`default_nettype none

module dataRam import cpuPkg::*; (
	input wire logic clock,
	input wire ramAddrT ramAddr,
	input wire logic ramWriteEn,
	input wire wordT ramWriteData,
	output wordT ramReadData
);

	wordT mem [ramDepth];

	// Read returns the old word when a write hits the same address
	always_ff @(posedge clock) begin
		if (ramWriteEn) begin
			mem[ramAddr] <= ramWriteData;
		end
		ramReadData <= mem[ramAddr];
	end

endmodule

`default_nettype wire

// ==== src/aluUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

module aluUnit import cpuPkg::*; (
	input wire logic clock,
	input wire logic rstN,
	input wire aluOpT aluOp,
	input wire wordT operandA,
	input wire wordT operandB,
	input wire logic flagsUpdate,
	input wire logic cmpUpdate,
	output wordT aluResult,
	output flagsT flags
);

	always_comb begin
		case (aluOp)
			aluAdd: aluResult = operandA + operandB;
			aluSub: aluResult = operandA - operandB;
			aluXor: aluResult = operandA ^ operandB;
			aluOr: aluResult = operandA | operandB;
			aluAnd: aluResult = operandA & operandB;
			aluNot: aluResult = ~operandA;
			// Single-bit shifts, zero filled
			aluShl: aluResult = {operandA[dataWidth-2:0], 1'b0};
			aluShr: aluResult = {1'b0, operandA[dataWidth-1:1]};
			aluPass: aluResult = operandB;
			default: aluResult = operandB;
		endcase
	end

	// Flag word
	always_ff @(posedge clock) begin
		if (!rstN) begin
			flags <= '0;
		end else if (cmpUpdate) begin
			// Compare refreshes everything, zero tracks equality
			flags.equal <= operandA == operandB;
			flags.greater <= operandA > operandB;
			flags.zero <= operandA == operandB;
		end else if (flagsUpdate) begin
			flags.zero <= aluResult == '0;
		end
	end

endmodule

`default_nettype wire

// ==== src/registerFile.sv ====
`timescale 1ns/100ps
`default_nettype none

module registerFile import cpuPkg::*; (
	input wire logic clock,
	input wire logic rstN,
	regFileIf.regFile rf
);

	wordT regs [2**regAddrWidth];

	always_ff @(posedge clock) begin
		if (!rstN) begin
			for (int i = 0; i < 2**regAddrWidth; i++) begin
				regs[i] <= '0;
			end
		end else if (rf.writeEn) begin
			regs[rf.writeAddr] <= rf.writeData;
		end
	end

	// Both read ports are plain muxes
	assign rf.readDataA = regs[rf.readAddrA];
	assign rf.readDataB = regs[rf.readAddrB];

endmodule

`default_nettype wire

// ==== src/regFileIf.sv ====
`timescale 1ns/100ps
`default_nettype none

interface regFileIf import cpuPkg::*; ();

	regAddrT readAddrA;
	regAddrT readAddrB;
	wordT readDataA;
	wordT readDataB;
	logic writeEn;
	regAddrT writeAddr;
	wordT writeData;

	modport decoder (
		output readAddrA, readAddrB, writeEn, writeAddr, writeData,
		input readDataA, readDataB
	);

	modport regFile (
		input readAddrA, readAddrB, writeEn, writeAddr, writeData,
		output readDataA, readDataB
	);

endinterface

`default_nettype wire

// ==== src/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

	localparam int dataWidth = 16;
	localparam int regAddrWidth = 4;
	localparam int ramAddrWidth = 13;
	localparam int ramDepth = 8192;

	typedef logic [dataWidth-1:0] wordT;
	typedef logic [regAddrWidth-1:0] regAddrT;
	typedef logic [ramAddrWidth-1:0] ramAddrT;

	// Unique legacy encodings kept, new codes for the former duplicates
	typedef enum logic [7:0] {
		opAddReg = 8'h01, opAddConst = 8'h21, opSubReg = 8'h02, opSubConst = 8'h22,
		opXor = 8'h03, opOr = 8'h04, opAnd = 8'h05, opNot = 8'h06,
		opShl = 8'h0B, opShr = 8'h0C,
		opMovReg = 8'h07, opMovConst = 8'h27,
		opStoreReg = 8'h87, opStoreConst = 8'hC7, opLoad = 8'h47,
		opCmp = 8'h08,
		opJmpReg = 8'h09, opJmpConst = 8'h89,
		opJzReg = 8'h29, opJzConst = 8'hA9, opJnzReg = 8'h49, opJnzConst = 8'hC9,
		opJgReg = 8'h69, opJgConst = 8'hE9, opJsReg = 8'h19, opJsConst = 8'h99,
		opJeqReg = 8'h59, opJeqConst = 8'hD9, opJnqReg = 8'h39, opJnqConst = 8'hB9,
		opJgqReg = 8'hF9, opJgqConst = 8'h0A, opJsqReg = 8'h8A, opJsqConst = 8'h4A
	} opcodeT;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluXor, aluOr, aluAnd, aluNot, aluShl, aluShr, aluPass
	} aluOpT;

	// Greater is an unsigned compare of A against B
	typedef struct packed {
		logic equal;
		logic greater;
		logic zero;
	} flagsT;

endpackage

`default_nettype wire
